// File: Makefile
# Verilator build and run of the writeback stage testbench

TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = wb_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
+incdir+include
rtl/wb_pkg.sv
rtl/wb_load_unit.sv
rtl/wb_flow_unit.sv
rtl/wb_pc_tracker.sv
rtl/wb_commit_ctrl.sv
rtl/wb_stage_top.sv
dv/wb_checker.sv
dv/wb_tb.sv

// File: dv/wb_checker.sv
// --------------------------------------------------
// Handshake rules of the writeback stage, bound into
// wb_stage_top. Failures are also counted in fail_count
// --------------------------------------------------
`timescale 1ns/1ns

`include "wb_config.svh"

module wb_checker (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            s4_valid,
    input  wb_pkg::fu_t     s4_fu,
    input  logic            s4_busy,
    input  logic            dmem_recv,
    input  logic            dmem_ack,
    input  logic            gpr_wen,
    input  logic            trap_cpu,
    input  logic            cf_req,
    input  logic            cf_ack,
    input  wb_pkg::xlen_t   cf_target,
    input  logic            trs_valid
);

    import wb_pkg::*;

    int     fail_count = 0;     // Read by the testbench at the end
    logic   traced_q;           // Current instruction already traced
    logic   rsp_taken_q;        // Response consumed, instruction still held
    logic   progress;

    assign progress = s4_valid && !s4_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            traced_q <= 1'b0;
        end else if (progress) begin
            traced_q <= 1'b0;   // Next instruction
        end else if (trs_valid) begin
            traced_q <= 1'b1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_taken_q <= 1'b0;
        end else if (progress) begin
            rsp_taken_q <= 1'b0;
        end else if (dmem_recv && dmem_ack) begin
            rsp_taken_q <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Request and target held until the ack
    a_cf_hold : assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> cf_req && $stable(cf_target))
        else begin
            fail_count++;
            $error("cf_req dropped or cf_target moved before cf_ack");
        end

    a_no_trap_write : assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(gpr_wen && trap_cpu))
        else begin
            fail_count++;
            $error("gpr_wen high together with trap_cpu");
        end

    // Ack only while a memory instruction waits for its response
    a_ack_valid : assert property (@(posedge g_clk) disable iff (!g_resetn)
        dmem_ack |-> s4_valid && (s4_fu == `WB_FU_LSU) && !rsp_taken_q)
        else begin
            fail_count++;
            $error("dmem_ack high without a memory instruction waiting for data");
        end

    a_one_trace : assert property (@(posedge g_clk) disable iff (!g_resetn)
        trs_valid |-> !traced_q)
        else begin
            fail_count++;
            $error("trs_valid seen twice for one instruction");
        end

endmodule

bind wb_stage_top wb_checker u_chk (.*);

// File: dv/wb_tb.sv
// --------------------------------------------------
// Directed and random stimulus for wb_stage_top
// Inputs change on falling edges, outputs sampled 1 ns later
// csr_mepc and csr_mtvec stay fixed for the whole run
// --------------------------------------------------
`timescale 1ns/1ns

`include "wb_config.svh"

module wb_tb;

    import wb_pkg::*;

    localparam int WAIT_LIMIT = 40;     // Cycles per handshake wait

    logic       g_clk;
    logic       g_resetn;
    logic       s4_valid;
    logic       s4_trap;
    logic       s4_busy;
    reg_addr_t  s4_rd;
    reg_addr_t  gpr_rd;
    uop_t       s4_uop;
    fu_t        s4_fu;
    isize_t     s4_size;
    xlen_t      s4_opr_a, s4_opr_b, s4_instr;
    logic       dmem_recv, dmem_ack, dmem_error;
    xlen_t      dmem_rdata;
    logic       gpr_wen;
    xlen_t      gpr_wdata;
    logic       cf_req, cf_ack, exec_mret;
    xlen_t      cf_target, csr_mepc, csr_mtvec;
    logic       trap_cpu;
    cause_t     trap_cause;
    xlen_t      trap_pc;
    xlen_t      trs_pc, trs_instr;
    logic       trs_valid;

    int         err_count;
    int         test_count;
    int         test_fails;
    int         mret_pulses;
    int         mark;           // Error total at test start
    xlen_t      exp_pc;         // Model of the stage PC

    wb_stage_top u_dut (.*);

    always #5 g_clk = ~g_clk;

    // --------------------------------------------------
    // Checks and reporting
    function automatic int error_total();
        return err_count + u_dut.u_chk.fail_count;
    endfunction

    task automatic check_val(string name, xlen_t exp, xlen_t act);
        if (exp !== act) begin
            err_count++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            err_count++;
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic report_test(string name);
        int errs;
        errs = error_total() - mark;
        test_count++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            test_fails++;
            $display("test %s: failed with %0d errors", name, errs);
        end
        mark = error_total();
    endtask

    // Load result from the byte lanes, independent of the RTL
    function automatic xlen_t expect_load(xlen_t data, logic [1:0] off,
                                          logic [1:0] width, logic sgn);
        xlen_t sh;
        sh = data >> {off, 3'b000};
        if (width == `WB_LSU_BYTE) begin
            return {{24{sgn & sh[7]}}, sh[7:0]};
        end else if (width == `WB_LSU_HALF) begin
            return {{16{sgn & sh[15]}}, sh[15:0]};
        end
        return data;
    endfunction

    // --------------------------------------------------
    // Stimulus, each task starts at a falling edge
    task automatic issue(fu_t fu, uop_t uop, xlen_t a, xlen_t b, isize_t size);
        s4_valid = 1'b1;
        s4_trap  = 1'b0;
        s4_fu    = fu;
        s4_uop   = uop;
        s4_opr_a = a;
        s4_opr_b = b;
        s4_size  = size;
        s4_rd    = reg_addr_t'($urandom_range(1, 31));
        s4_instr = $urandom();
    endtask

    task automatic wait_dmem_ack();
        int n;
        n = 0;
        while (dmem_ack !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge g_clk);
            #1;
            n++;
        end
        if (dmem_ack !== 1'b1) begin
            err_count++;
            $display("Timeout: dmem_ack did not rise within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic wait_cf_req();
        int n;
        n = 0;
        while (cf_req !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge g_clk);
            #1;
            n++;
        end
        if (cf_req !== 1'b1) begin
            err_count++;
            $display("Timeout: cf_req did not rise within %0d cycles", WAIT_LIMIT);
        end
    endtask

    // Random delay, then one response cycle left driven
    task automatic respond(xlen_t data, logic error);
        int delay;
        delay = $urandom_range(0, 3);
        repeat (delay) begin
            @(negedge g_clk);
            #1;
            check_bit("dmem_ack", 1'b1, dmem_ack);
            check_bit("s4_busy", 1'b1, s4_busy);
            check_bit("gpr_wen", 1'b0, gpr_wen);
        end
        @(negedge g_clk);
        dmem_recv  = 1'b1;
        dmem_error = error;
        dmem_rdata = data;
        #1;
    endtask

    // Hold cf_ack low a random time, ack, then check the new PC
    task automatic ack_change(xlen_t target, int max_delay);
        int delay;
        delay = $urandom_range(0, max_delay);
        repeat (delay) begin
            @(negedge g_clk);
            #1;
            check_bit("cf_req", 1'b1, cf_req);
            check_bit("s4_busy", 1'b1, s4_busy);
            check_val("cf_target", target, cf_target);
            mret_pulses += exec_mret ? 1 : 0;
        end
        @(negedge g_clk);
        cf_ack = 1'b1;
        #1;
        check_bit("s4_busy", 1'b0, s4_busy);
        check_bit("trs_valid", 1'b1, trs_valid);
        check_val("trs_pc", exp_pc, trs_pc);
        mret_pulses += exec_mret ? 1 : 0;
        @(negedge g_clk);
        cf_ack   = 1'b0;
        s4_valid = 1'b0;
        exp_pc   = target;
        #1;
        check_val("trs_pc", exp_pc, trs_pc);
        mret_pulses += exec_mret ? 1 : 0;
    endtask

    task automatic run_load(logic [1:0] width, logic [1:0] off, logic sgn);
        xlen_t      addr;
        xlen_t      data;
        logic [3:0] strb;
        addr = $urandom();
        addr[1:0] = off;
        data = $urandom();
        strb = (width == `WB_LSU_BYTE) ? 4'b0001 << off :
               (width == `WB_LSU_HALF) ? 4'b0011 << off : 4'b1111;
        @(negedge g_clk);
        issue(`WB_FU_LSU, {2'b01, width, sgn}, {28'h0, strb}, addr, 2'd2);  // Load bit set
        #1;
        wait_dmem_ack();
        respond(data, 1'b0);
        check_bit("gpr_wen", 1'b1, gpr_wen);
        check_val("gpr_rd", 32'(s4_rd), 32'(gpr_rd));
        check_val("gpr_wdata", expect_load(data, off, width, sgn), gpr_wdata);
        check_bit("s4_busy", 1'b0, s4_busy);
        check_val("trs_pc", exp_pc, trs_pc);
        exp_pc = exp_pc + 32'd4;
        @(negedge g_clk);
        dmem_recv = 1'b0;
        s4_valid  = 1'b0;
    endtask

    task automatic run_bus_error(logic store);
        xlen_t addr;
        addr = $urandom() & 32'hffff_fffc;
        @(negedge g_clk);
        // Word access, {store, load, width, signed}
        issue(`WB_FU_LSU, {store, !store, `WB_LSU_WORD, 1'b0}, 32'h0000_000f, addr, 2'd2);
        #1;
        wait_dmem_ack();
        respond($urandom(), 1'b1);
        check_bit("trap_cpu", 1'b1, trap_cpu);
        check_val("trap_cause", store ? 32'd7 : 32'd5, 32'(trap_cause));
        check_val("trap_pc", exp_pc, trap_pc);
        check_bit("cf_req", 1'b1, cf_req);
        check_val("cf_target", csr_mtvec, cf_target);
        check_bit("gpr_wen", 1'b0, gpr_wen);
        @(negedge g_clk);
        dmem_recv  = 1'b0;      // Error must stay latched
        dmem_error = 1'b0;
        #1;
        check_bit("cf_req", 1'b1, cf_req);
        check_bit("gpr_wen", 1'b0, gpr_wen);
        ack_change(csr_mtvec, 3);
    endtask

    task automatic run_change(uop_t uop, xlen_t opr, xlen_t target, int max_delay,
                              cause_t cause);
        xlen_t link;
        link = exp_pc + 32'd4;
        mret_pulses = 0;
        @(negedge g_clk);
        issue(`WB_FU_CFU, uop, opr, 32'h0, 2'd2);
        #1;
        wait_cf_req();
        check_val("cf_target", target, cf_target);
        check_bit("trap_cpu", cause != 6'd0, trap_cpu);
        if (cause != 6'd0) begin
            check_val("trap_cause", 32'(cause), 32'(trap_cause));
            check_val("trap_pc", exp_pc, trap_pc);
        end
        check_bit("gpr_wen", uop == `WB_CFU_JAL, gpr_wen);
        if (uop == `WB_CFU_JAL) begin
            check_val("gpr_wdata", link, gpr_wdata);
        end
        mret_pulses += exec_mret ? 1 : 0;
        ack_change(target, max_delay);
        check_val("exec_mret pulses", (uop == `WB_CFU_MRET) ? 32'd1 : 32'd0, mret_pulses);
    endtask

    // --------------------------------------------------
    // Main sequence
    initial begin
        void'($urandom(32'h4e4c));
        g_clk      = 1'b0;
        g_resetn   = 1'b0;
        s4_valid   = 1'b0;
        s4_trap    = 1'b0;
        s4_rd      = '0;
        s4_uop     = '0;
        s4_fu      = '0;
        s4_size    = '0;
        s4_opr_a   = '0;
        s4_opr_b   = '0;
        s4_instr   = '0;
        dmem_recv  = 1'b0;
        dmem_error = 1'b0;
        dmem_rdata = '0;
        cf_ack     = 1'b0;
        csr_mepc   = $urandom() & 32'hffff_fffc;
        csr_mtvec  = $urandom() & 32'hffff_fffc;
        err_count  = 0;
        test_count = 0;
        test_fails = 0;
        mark       = 0;
        exp_pc     = `WB_PC_RESET;

        repeat (4) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        #1;
        check_bit("cf_req", 1'b0, cf_req);
        check_bit("dmem_ack", 1'b0, dmem_ack);
        check_bit("gpr_wen", 1'b0, gpr_wen);
        check_bit("exec_mret", 1'b0, exec_mret);
        check_bit("trs_valid", 1'b0, trs_valid);
        check_val("trs_pc", exp_pc, trs_pc);
        report_test("reset");

        for (int i = 0; i < 6; i++) begin
            @(negedge g_clk);
            issue(`WB_FU_ALU, 5'd0, $urandom(), $urandom(), isize_t'(i % 2 + 1));
            #1;
            check_bit("gpr_wen", 1'b1, gpr_wen);
            check_val("gpr_rd", 32'(s4_rd), 32'(gpr_rd));
            check_val("gpr_wdata", s4_opr_a, gpr_wdata);
            check_bit("s4_busy", 1'b0, s4_busy);
            check_bit("trs_valid", 1'b1, trs_valid);
            check_val("trs_pc", exp_pc, trs_pc);
            check_val("trs_instr", s4_instr, trs_instr);
            exp_pc = exp_pc + 2 * 32'(s4_size);     // Size counts halfwords
        end
        @(negedge g_clk);
        s4_valid = 1'b0;
        report_test("alu writeback");

        for (int rep = 0; rep < 2; rep++) begin
            for (int w = 1; w < 4; w++) begin
                for (int off = 0; off < 4; off++) begin
                    for (int sgn = 0; sgn < 2; sgn++) begin
                        // Halves on even offsets, words aligned
                        if (w == 1 || (w == 2 && off % 2 == 0) || off == 0) begin
                            run_load(w[1:0], off[1:0], sgn[0]);
                        end
                    end
                end
            end
        end
        report_test("load alignment");

        run_bus_error(1'b0);
        run_bus_error(1'b1);
        report_test("bus error");

        run_change(`WB_CFU_JAL, 32'h8000_0100, 32'h8000_0100, 3, 6'd0);
        run_change(`WB_CFU_TAKEN, 32'h8000_0040, 32'h8000_0040, 3, 6'd0);
        report_test("jumps");

        run_change(`WB_CFU_ECALL, $urandom(), csr_mtvec, 3, 6'd11);
        run_change(`WB_CFU_EBREAK, $urandom(), csr_mtvec, 3, 6'd3);
        run_change(`WB_CFU_MRET, $urandom(), csr_mepc, 3, 6'd0);
        report_test("ecall ebreak mret");

        for (int i = 0; i < 6; i++) begin
            run_change((i % 2 == 0) ? `WB_CFU_JAL : `WB_CFU_TAKEN,
                       exp_pc + 32'h0000_0200, exp_pc + 32'h0000_0200, 8, 6'd0);
        end
        report_test("back-pressure");

        repeat (2) @(negedge g_clk);
        $display("Tests: %0d run, %0d failed, %0d errors", test_count, test_fails,
                 error_total());
        if (error_total() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: include/wb_config.svh
// --------------------------------------------------
// Widths, reset PC and the micro-op encodings shared by
// the writeback stage and its testbench
// --------------------------------------------------
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// Data path
`define WB_XLEN             32
`define WB_PC_RESET         32'h8000_0000

// Functional unit codes
`define WB_FU_ALU           2'd0    // ALU class result in s4_opr_a
`define WB_FU_LSU           2'd1    // Load or store
`define WB_FU_CFU           2'd2    // Control flow

// CFU micro-ops
`define WB_CFU_TAKEN        5'd1    // Taken branch
`define WB_CFU_JAL          5'd2    // Jump and link
`define WB_CFU_ECALL        5'd3
`define WB_CFU_EBREAK       5'd4
`define WB_CFU_MRET         5'd5

// LSU micro-op bit positions
`define WB_LSU_SIGNED       0
`define WB_LSU_LOAD         3
`define WB_LSU_STORE        4

// Access width in uop[2:1]
`define WB_LSU_BYTE         2'b01
`define WB_LSU_HALF         2'b10
`define WB_LSU_WORD         2'b11

// Trap causes
`define WB_TRAP_BREAKPT     6'd3
`define WB_TRAP_LDACCESS    6'd5
`define WB_TRAP_STACCESS    6'd7
`define WB_TRAP_ECALLM      6'd11

`endif

// File: rtl/wb_commit_ctrl.sv
// --------------------------------------------------
// Stall, register write and trap reporting
// Writes blocked on any flagged trap or bus error
// --------------------------------------------------
`timescale 1ns/1ns

`include "wb_config.svh"

module wb_commit_ctrl (
    input  logic                s4_valid,
    input  wb_pkg::fu_t         s4_fu,
    input  wb_pkg::reg_addr_t   s4_rd,
    input  wb_pkg::xlen_t       s4_opr_a,
    input  logic                s4_trap,
    input  wb_pkg::uop_t        s4_uop,
    input  logic                lsu_busy,
    input  logic                lsu_wen,
    input  wb_pkg::xlen_t       lsu_wdata,
    input  logic                lsu_error,
    input  logic                cfu_busy,
    input  logic                cfu_link,
    input  wb_pkg::cause_t      cfu_trap_cause,
    input  logic                cf_req,
    input  logic                cf_ack,
    input  wb_pkg::xlen_t       next_pc,
    input  wb_pkg::xlen_t       s4_pc,
    output logic                s4_busy,
    output logic                pipe_progress,
    output logic                gpr_wen,
    output wb_pkg::reg_addr_t   gpr_rd,
    output wb_pkg::xlen_t       gpr_wdata,
    output logic                trap_cpu,
    output wb_pkg::cause_t      trap_cause,
    output wb_pkg::xlen_t       trap_pc
);

    import wb_pkg::*;

    logic       alu_wen;
    logic       cfu_trap;
    logic       wr_block;

    // --------------------------------------------------
    // Stall and progress
    assign s4_busy       = lsu_busy || cfu_busy || (cf_req && !cf_ack);
    assign pipe_progress = s4_valid && !s4_busy;

    // --------------------------------------------------
    // Register write
    assign alu_wen   = s4_valid && (s4_fu == `WB_FU_ALU);
    assign wr_block  = (s4_valid && s4_trap) || lsu_error;
    assign gpr_wen   = (alu_wen || lsu_wen || cfu_link) && !wr_block;
    assign gpr_rd    = s4_rd;
    assign gpr_wdata = lsu_wen  ? lsu_wdata :
                       cfu_link ? next_pc   :   // Link address
                                  s4_opr_a;

    // --------------------------------------------------
    // Traps
    assign cfu_trap = |cfu_trap_cause;
    assign trap_cpu = wr_block || cfu_trap;
    assign trap_pc  = s4_pc;

    assign trap_cause =
        lsu_error && s4_uop[`WB_LSU_LOAD]  ? `WB_TRAP_LDACCESS :
        lsu_error && s4_uop[`WB_LSU_STORE] ? `WB_TRAP_STACCESS :
        cfu_trap                           ? cfu_trap_cause    :
                                             s4_opr_a[5:0];     // Upstream cause

endmodule

// File: rtl/wb_flow_unit.sv
// --------------------------------------------------
// Control flow changes. cf_req and cf_target stay put
// until cf_ack, request dropped once acked
// --------------------------------------------------
`timescale 1ns/1ns

`include "wb_config.svh"

module wb_flow_unit (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            s4_valid,
    input  wb_pkg::fu_t     s4_fu,
    input  wb_pkg::uop_t    s4_uop,
    input  logic            s4_trap,
    input  wb_pkg::xlen_t   s4_opr_a,   // Branch or jump target
    input  logic            lsu_error,
    input  wb_pkg::xlen_t   csr_mepc,
    input  wb_pkg::xlen_t   csr_mtvec,
    input  logic            cf_ack,
    input  logic            pipe_progress,
    output logic            cf_req,
    output wb_pkg::xlen_t   cf_target,
    output logic            cfu_busy,
    output logic            cfu_link,
    output wb_pkg::cause_t  cfu_trap_cause,
    output logic            exec_mret,
    output logic            cf_done
);

    import wb_pkg::*;

    cf_state_t  state_q;

    logic       fu_cfu;
    logic       cfu_taken;
    logic       cfu_ecall;
    logic       cfu_ebreak;
    logic       cfu_mret;
    logic       cfu_trap;
    logic       tgt_trap;
    logic       cfu_op;
    logic       finish_now;

    // --------------------------------------------------
    // Decode
    assign fu_cfu     = s4_valid && (s4_fu == `WB_FU_CFU);
    assign cfu_link   = fu_cfu && (s4_uop == `WB_CFU_JAL);
    assign cfu_taken  = fu_cfu && (s4_uop == `WB_CFU_TAKEN) || cfu_link;
    assign cfu_ecall  = fu_cfu && (s4_uop == `WB_CFU_ECALL);
    assign cfu_ebreak = fu_cfu && (s4_uop == `WB_CFU_EBREAK);
    assign cfu_mret   = fu_cfu && (s4_uop == `WB_CFU_MRET);
    assign cfu_trap   = cfu_ecall || cfu_ebreak;
    assign cfu_op     = cfu_taken || cfu_trap || cfu_mret;

    // Any trap heads for the handler
    assign tgt_trap   = cfu_trap || (s4_valid && s4_trap) || lsu_error;

    assign cfu_trap_cause = cfu_ebreak ? `WB_TRAP_BREAKPT :
                            cfu_ecall  ? `WB_TRAP_ECALLM  :
                                         6'd0;          // Zero means no CFU trap

    // --------------------------------------------------
    // Request and target
    assign cf_done = (state_q == CF_DONE);
    assign cf_req  = (cfu_op || tgt_trap) && !cf_done;

    assign cf_target = tgt_trap ? csr_mtvec :
                       cfu_mret ? csr_mepc  :
                                  s4_opr_a;

    assign finish_now = cf_req && cf_ack;
    assign cfu_busy   = cfu_op && !(cf_done || finish_now);
    assign exec_mret  = cfu_mret && pipe_progress;      // One pulse per MRET

    // Acked change, stage held by something else
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state_q <= CF_IDLE;
        end else if (pipe_progress) begin
            state_q <= CF_IDLE;
        end else if (finish_now) begin
            state_q <= CF_DONE;
        end
    end

endmodule

// File: rtl/wb_load_unit.sv
// --------------------------------------------------
// Load and store completion. s4_opr_a[3:0] carries the
// byte strobes and must match offset and width
// Misaligned offsets give undefined load data
// --------------------------------------------------
`timescale 1ns/1ns

`include "wb_config.svh"

module wb_load_unit (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            s4_valid,
    input  wb_pkg::fu_t     s4_fu,
    input  wb_pkg::uop_t    s4_uop,
    input  wb_pkg::xlen_t   s4_opr_a,   // Strobes in [3:0]
    input  wb_pkg::xlen_t   s4_opr_b,   // Access address
    input  logic            dmem_recv,
    input  logic            dmem_error,
    input  wb_pkg::xlen_t   dmem_rdata,
    input  logic            pipe_progress,
    output logic            dmem_ack,
    output logic            lsu_busy,
    output logic            lsu_wen,
    output wb_pkg::xlen_t   lsu_wdata,
    output logic            lsu_error
);

    import wb_pkg::*;

    lsu_state_t state_q;
    logic       err_q;              // Bus error seen, held until progress

    logic       fu_lsu;
    logic       rsp_take;           // Response consumed this cycle
    logic [1:0] addr;
    logic [3:0] strb;
    logic       is_byte;
    logic       is_half;
    logic       is_word;
    logic       is_signed;
    logic [7:0] rd_b0;
    logic [7:0] rd_b1;
    logic [15:0] rd_h1;

    assign fu_lsu   = s4_valid && (s4_fu == `WB_FU_LSU);
    assign dmem_ack = fu_lsu && (state_q == LSU_WAIT);
    assign rsp_take = dmem_recv && dmem_ack;

    // Stall until the response arrives
    assign lsu_busy  = fu_lsu && !(state_q == LSU_HELD || rsp_take);
    assign lsu_error = fu_lsu && (err_q || (rsp_take && dmem_error));
    assign lsu_wen   = rsp_take && !dmem_error && s4_uop[`WB_LSU_LOAD];

    // --------------------------------------------------
    // Response tracking
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state_q <= LSU_WAIT;
            err_q   <= 1'b0;
        end else if (pipe_progress) begin
            state_q <= LSU_WAIT;    // Next instruction
            err_q   <= 1'b0;
        end else if (rsp_take) begin
            state_q <= LSU_HELD;    // Never take a second response
            err_q   <= dmem_error;
        end
    end

    // --------------------------------------------------
    // Load data alignment
    assign addr      = s4_opr_b[1:0];
    assign strb      = s4_opr_a[3:0];
    assign is_byte   = s4_uop[2:1] == `WB_LSU_BYTE;
    assign is_half   = s4_uop[2:1] == `WB_LSU_HALF;
    assign is_word   = s4_uop[2:1] == `WB_LSU_WORD;
    assign is_signed = s4_uop[`WB_LSU_SIGNED];

    // Low byte from the addressed lane
    assign rd_b0 =
        {8{strb[0]}}                                & dmem_rdata[ 7: 0] |
        {8{is_byte && addr == 2'b01}}               & dmem_rdata[15: 8] |
        {8{is_byte && addr == 2'b10 || is_half && addr[1]}} & dmem_rdata[23:16] |
        {8{is_byte && addr == 2'b11}}               & dmem_rdata[31:24];

    // Second byte is data for half and word, sign for a byte
    assign rd_b1 =
        {8{is_byte && is_signed}}                   & {8{rd_b0[7]}} |
        {8{is_half && !addr[1]}}                    & dmem_rdata[15: 8] |
        {8{is_half && addr[1]}}                     & dmem_rdata[31:24] |
        {8{is_word}}                                & dmem_rdata[15: 8];

    assign rd_h1 =
        {16{(is_byte || is_half) && is_signed}}     & {16{rd_b1[7]}} |
        {16{is_word}}                               & dmem_rdata[31:16];

    assign lsu_wdata = {rd_h1, rd_b1, rd_b0};

endmodule

// File: rtl/wb_pc_tracker.sv
// --------------------------------------------------
// Program counter and instruction trace
// One trace packet per instruction with nonzero size
// --------------------------------------------------
`timescale 1ns/1ns

`include "wb_config.svh"

module wb_pc_tracker (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            s4_valid,
    input  wb_pkg::isize_t  s4_size,    // Halfwords
    input  wb_pkg::xlen_t   s4_instr,
    input  logic            cf_req,
    input  logic            cf_ack,
    input  wb_pkg::xlen_t   cf_target,
    input  logic            cf_done,
    input  logic            pipe_progress,
    output wb_pkg::xlen_t   s4_pc,
    output wb_pkg::xlen_t   next_pc,
    output wb_pkg::xlen_t   trs_pc,
    output wb_pkg::xlen_t   trs_instr,
    output logic            trs_valid
);

    import wb_pkg::*;

    logic       cf_taken;

    assign cf_taken = cf_req && cf_ack;
    assign next_pc  = s4_pc + {{(`WB_XLEN-3){1'b0}}, s4_size, 1'b0};

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s4_pc <= `WB_PC_RESET;
        end else if (cf_taken) begin
            s4_pc <= cf_target;     // Change wins over progress
        end else if (pipe_progress) begin
            s4_pc <= next_pc;
        end
    end

    // --------------------------------------------------
    // Trace
    assign trs_pc    = s4_pc;
    assign trs_instr = s4_instr;
    // Already traced at the ack if cf_done is set
    assign trs_valid = s4_valid && |s4_size && ((pipe_progress && !cf_done) || cf_taken);

endmodule

// File: rtl/wb_pkg.sv
// --------------------------------------------------
// Shared types of the writeback stage
// --------------------------------------------------

`include "wb_config.svh"

package wb_pkg;

    typedef logic [`WB_XLEN-1:0] xlen_t;    // Data or address word
    typedef logic [4:0]          reg_addr_t;
    typedef logic [1:0]          fu_t;
    typedef logic [4:0]          uop_t;
    typedef logic [1:0]          isize_t;   // Size in halfwords
    typedef logic [5:0]          cause_t;

    // Memory response tracking
    typedef enum logic {
        LSU_WAIT,   // No response taken yet
        LSU_HELD    // Response taken, stage stalled
    } lsu_state_t;

    // Control flow change tracking
    typedef enum logic {
        CF_IDLE,
        CF_DONE     // Change acked, stage still stalled
    } cf_state_t;

endpackage

// File: rtl/wb_stage_top.sv
// --------------------------------------------------
// Writeback stage, one instruction held at a time
// Inputs held by upstream while s4_valid && s4_busy
// --------------------------------------------------
`timescale 1ns/1ns

`include "wb_config.svh"

module wb_stage_top (
    input  logic                g_clk,
    input  logic                g_resetn,

    input  logic                s4_valid,
    input  wb_pkg::reg_addr_t   s4_rd,
    input  wb_pkg::xlen_t       s4_opr_a,
    input  wb_pkg::xlen_t       s4_opr_b,
    input  wb_pkg::uop_t        s4_uop,
    input  wb_pkg::fu_t         s4_fu,
    input  logic                s4_trap,
    input  wb_pkg::isize_t      s4_size,
    input  wb_pkg::xlen_t       s4_instr,
    output logic                s4_busy,

    input  logic                dmem_recv,
    output logic                dmem_ack,
    input  logic                dmem_error,
    input  wb_pkg::xlen_t       dmem_rdata,

    output logic                gpr_wen,
    output wb_pkg::reg_addr_t   gpr_rd,
    output wb_pkg::xlen_t       gpr_wdata,

    output logic                cf_req,
    output wb_pkg::xlen_t       cf_target,
    input  logic                cf_ack,

    output logic                exec_mret,
    input  wb_pkg::xlen_t       csr_mepc,
    input  wb_pkg::xlen_t       csr_mtvec,

    output logic                trap_cpu,
    output wb_pkg::cause_t      trap_cause,
    output wb_pkg::xlen_t       trap_pc,

    output wb_pkg::xlen_t       trs_pc,
    output wb_pkg::xlen_t       trs_instr,
    output logic                trs_valid
);

    import wb_pkg::*;

    // --------------------------------------------------
    // Internal wires
    logic       pipe_progress;
    logic       lsu_busy;
    logic       lsu_wen;
    xlen_t      lsu_wdata;
    logic       lsu_error;
    logic       cfu_busy;
    logic       cfu_link;
    cause_t     cfu_trap_cause;
    logic       cf_done;
    xlen_t      s4_pc;
    xlen_t      next_pc;

    wb_commit_ctrl u_commit (
        .s4_valid       (s4_valid),
        .s4_fu          (s4_fu),
        .s4_rd          (s4_rd),
        .s4_opr_a       (s4_opr_a),
        .s4_trap        (s4_trap),
        .s4_uop         (s4_uop),
        .lsu_busy       (lsu_busy),
        .lsu_wen        (lsu_wen),
        .lsu_wdata      (lsu_wdata),
        .lsu_error      (lsu_error),
        .cfu_busy       (cfu_busy),
        .cfu_link       (cfu_link),
        .cfu_trap_cause (cfu_trap_cause),
        .cf_req         (cf_req),
        .cf_ack         (cf_ack),
        .next_pc        (next_pc),
        .s4_pc          (s4_pc),
        .s4_busy        (s4_busy),
        .pipe_progress  (pipe_progress),
        .gpr_wen        (gpr_wen),
        .gpr_rd         (gpr_rd),
        .gpr_wdata      (gpr_wdata),
        .trap_cpu       (trap_cpu),
        .trap_cause     (trap_cause),
        .trap_pc        (trap_pc)
    );

    wb_load_unit u_load (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .s4_valid       (s4_valid),
        .s4_fu          (s4_fu),
        .s4_uop         (s4_uop),
        .s4_opr_a       (s4_opr_a),
        .s4_opr_b       (s4_opr_b),
        .dmem_recv      (dmem_recv),
        .dmem_error     (dmem_error),
        .dmem_rdata     (dmem_rdata),
        .pipe_progress  (pipe_progress),
        .dmem_ack       (dmem_ack),
        .lsu_busy       (lsu_busy),
        .lsu_wen        (lsu_wen),
        .lsu_wdata      (lsu_wdata),
        .lsu_error      (lsu_error)
    );

    wb_flow_unit u_flow (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .s4_valid       (s4_valid),
        .s4_fu          (s4_fu),
        .s4_uop         (s4_uop),
        .s4_trap        (s4_trap),
        .s4_opr_a       (s4_opr_a),
        .lsu_error      (lsu_error),
        .csr_mepc       (csr_mepc),
        .csr_mtvec      (csr_mtvec),
        .cf_ack         (cf_ack),
        .pipe_progress  (pipe_progress),
        .cf_req         (cf_req),
        .cf_target      (cf_target),
        .cfu_busy       (cfu_busy),
        .cfu_link       (cfu_link),
        .cfu_trap_cause (cfu_trap_cause),
        .exec_mret      (exec_mret),
        .cf_done        (cf_done)
    );

    wb_pc_tracker u_pc (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .s4_valid       (s4_valid),
        .s4_size        (s4_size),
        .s4_instr       (s4_instr),
        .cf_req         (cf_req),
        .cf_ack         (cf_ack),
        .cf_target      (cf_target),
        .cf_done        (cf_done),
        .pipe_progress  (pipe_progress),
        .s4_pc          (s4_pc),
        .next_pc        (next_pc),
        .trs_pc         (trs_pc),
        .trs_instr      (trs_instr),
        .trs_valid      (trs_valid)
    );

endmodule
